// ==== logic/armCtrlPkg.sv ====
package armCtrlPkg;

  typedef logic [3:0] aluCtrlT;   // Same encoding as the DP opcode field
  typedef logic [1:0] memSizeT;

  // Two views of one instruction word
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        imm;
      logic [3:0]  opcode;
      logic        s;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand;
    } dpView;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        regOffset;
      logic        pBit;
      logic        uBit;
      logic        bBit;        // Immediate select in halfword transfers
      logic        wBit;
      logic        lBit;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } memView;
  } instrU;

  // ALU opcodes
  localparam aluCtrlT ALU_AND = 4'b0000;
  localparam aluCtrlT ALU_EOR = 4'b0001;
  localparam aluCtrlT ALU_SUB = 4'b0010;
  localparam aluCtrlT ALU_RSB = 4'b0011;
  localparam aluCtrlT ALU_ADD = 4'b0100;
  localparam aluCtrlT ALU_ADC = 4'b0101;
  localparam aluCtrlT ALU_SBC = 4'b0110;
  localparam aluCtrlT ALU_RSC = 4'b0111;
  localparam aluCtrlT ALU_TST = 4'b1000;
  localparam aluCtrlT ALU_TEQ = 4'b1001;
  localparam aluCtrlT ALU_CMP = 4'b1010;
  localparam aluCtrlT ALU_CMN = 4'b1011;
  localparam aluCtrlT ALU_ORR = 4'b1100;
  localparam aluCtrlT ALU_MOV = 4'b1101;
  localparam aluCtrlT ALU_BIC = 4'b1110;
  localparam aluCtrlT ALU_MVN = 4'b1111;

  localparam memSizeT SIZE_WORD = 2'b00;
  localparam memSizeT SIZE_HALF = 2'b01;
  localparam memSizeT SIZE_BYTE = 2'b10;

  // Condition field codes where 1111 behaves as always
  localparam logic [3:0] COND_EQ = 4'h0;
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_CS = 4'h2;
  localparam logic [3:0] COND_CC = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'ha;
  localparam logic [3:0] COND_LT = 4'hb;
  localparam logic [3:0] COND_GT = 4'hc;
  localparam logic [3:0] COND_LE = 4'hd;
  localparam logic [3:0] COND_AL = 4'he;

  localparam logic [3:0] REG_PC = 4'd15;

  // Immediate extension select
  localparam logic [1:0] IMM_DP   = 2'b00;
  localparam logic [1:0] IMM_MEM  = 2'b01;
  localparam logic [1:0] IMM_BR   = 2'b10;
  localparam logic [1:0] IMM_HALF = 2'b11;   // Split 8-bit halfword offset

  // Register read source bits
  localparam logic [1:0] REG_SRC_PC = 2'b01;   // PC in place of Rn
  localparam logic [1:0] REG_SRC_RD = 2'b10;   // Rd as second read for stores

  localparam logic [23:0] BX_PATTERN = 24'h12fff1;   // Bits 27:4 of BX

endpackage

// ==== logic/mainDecoder.sv ====
`timescale 1ns/100ps

module mainDecoder import armCtrlPkg::*; (
  input  instrU      instrD,
  output logic [1:0] regSrcD,
  output logic [1:0] immSrcD,
  output logic       aluSrcD,
  output logic       memtoRegD,
  output logic       regWriteD,
  output logic       memWriteD,
  output logic       branchD,
  output logic       aluOpD,
  output logic       multD,
  output logic       pcSrcD,
  output aluCtrlT    aluControlD,
  output logic [1:0] flagWriteD,
  output memSizeT    sizeD
);

  logic       isMult;
  logic       isHalf;
  logic       isBx;
  logic       isCompare;
  logic [3:0] destReg;

  // Sub-formats hidden inside op 00
  assign isMult = (instrD[27:22] == 6'b000000) && (instrD[7:4] == 4'b1001);
  assign isHalf = (instrD.dpView.op == 2'b00) && !instrD.dpView.imm
                  && (instrD[7:4] == 4'b1011);
  assign isBx   = (instrD[27:4] == BX_PATTERN);

  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = IMM_DP;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    aluOpD      = 1'b0;
    multD       = 1'b0;
    aluControlD = ALU_ADD;
    flagWriteD  = 2'b00;
    sizeD       = SIZE_WORD;
    case (instrD.dpView.op)
      2'b00: begin
        if (isMult) begin               // MUL / MLA
          regWriteD  = 1'b1;
          multD      = 1'b1;
          flagWriteD = {2{instrD.dpView.s}};
        end else if (isHalf) begin      // LDRH / STRH
          immSrcD     = IMM_HALF;
          aluSrcD     = instrD.memView.bBit;
          aluControlD = instrD.memView.uBit ? ALU_ADD : ALU_SUB;
          sizeD       = SIZE_HALF;
          if (instrD.memView.lBit) begin
            memtoRegD = 1'b1;
            regWriteD = 1'b1;
          end else begin
            regSrcD   = REG_SRC_RD;
            memWriteD = 1'b1;
          end
        end else if (isBx) begin
          aluControlD = ALU_MOV;        // Rm passes through as target
          branchD     = 1'b1;
        end else begin                  // Data processing
          aluSrcD     = instrD.dpView.imm;
          regWriteD   = 1'b1;
          aluOpD      = 1'b1;
          aluControlD = instrD.dpView.opcode;
          flagWriteD  = {2{instrD.dpView.s}};
        end
      end
      2'b01: begin                      // LDR / STR / LDRB / STRB
        immSrcD     = IMM_MEM;
        aluSrcD     = !instrD.memView.regOffset;
        aluControlD = instrD.memView.uBit ? ALU_ADD : ALU_SUB;
        sizeD       = instrD.memView.bBit ? SIZE_BYTE : SIZE_WORD;
        if (instrD.memView.lBit) begin
          memtoRegD = 1'b1;
          regWriteD = 1'b1;
        end else begin
          regSrcD   = REG_SRC_RD;
          memWriteD = 1'b1;
        end
      end
      2'b10: begin                      // B with target PC plus offset
        regSrcD = REG_SRC_PC;
        immSrcD = IMM_BR;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;                        // Coprocessor space unsupported
    endcase
  end

  // Multiply keeps its destination in the Rn slot
  assign destReg   = multD ? instrD.dpView.rn : instrD.dpView.rd;
  assign isCompare = aluOpD && (instrD.dpView.opcode[3:2] == 2'b10);
  assign pcSrcD    = branchD || (regWriteD && !isCompare && (destReg == REG_PC));

  always_comb begin
    noWriteOp11: assert (!(regWriteD && (instrD.dpView.op == 2'b11)))
      else $error("register write decoded from op 11");
  end

endmodule

// ==== logic/aluDecoder.sv ====
`timescale 1ns/100ps

module aluDecoder import armCtrlPkg::*; (
  input  logic    aluOpE,
  input  aluCtrlT aluControlE,
  input  logic    carryFlagE,
  output logic    noWriteE,
  output logic    aluCarryE,
  output logic    invertBE
);

  // Carry-in and B inversion turn the adder into each add/sub form
  always_comb begin
    case (aluControlE)
      ALU_ADC: begin
        aluCarryE = carryFlagE;
        invertBE  = 1'b0;
      end
      ALU_SBC: begin
        aluCarryE = carryFlagE;   // A + ~B + C
        invertBE  = 1'b1;
      end
      ALU_SUB, ALU_CMP: begin
        aluCarryE = 1'b1;         // A + ~B + 1
        invertBE  = 1'b1;
      end
      default: begin
        aluCarryE = 1'b0;
        invertBE  = 1'b0;
      end
    endcase
  end

  // Loads and stores also use SUB, but only true DP ops can be tests
  always_comb begin
    noWriteE = 1'b0;
    if (aluOpE) begin
      case (aluControlE)
        ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN: noWriteE = 1'b1;
        default:                            noWriteE = 1'b0;
      endcase
    end
  end

endmodule

// ==== logic/condUnit.sv ====
`timescale 1ns/100ps

module condUnit import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallE,
  input  logic [3:0] condE,
  input  logic [3:0] flagsE,       // NZCV from the ALU
  input  logic [1:0] flagWriteE,   // Bit 1 NZ, bit 0 CV
  output logic       condExE,
  output logic [3:0] storedFlags
);

  logic n;
  logic z;
  logic c;
  logic v;
  logic ge;

  assign {n, z, c, v} = storedFlags;
  assign ge = (n == v);

  // ==============================
  // Condition check
  // ==============================
  always_comb begin
    case (condE)
      COND_EQ: condExE = z;
      COND_NE: condExE = !z;
      COND_CS: condExE = c;
      COND_CC: condExE = !c;
      COND_MI: condExE = n;
      COND_PL: condExE = !n;
      COND_VS: condExE = v;
      COND_VC: condExE = !v;
      COND_HI: condExE = c && !z;
      COND_LS: condExE = !c || z;
      COND_GE: condExE = ge;
      COND_LT: condExE = !ge;
      COND_GT: condExE = !z && ge;
      COND_LE: condExE = z || !ge;
      COND_AL: condExE = 1'b1;
      default: condExE = 1'b1;   // Unconditional space
    endcase
  end

  // ==============================
  // Flag register
  // ==============================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      storedFlags <= 4'b0000;
    end else if (!stallE && condExE) begin
      if (flagWriteE[1]) begin
        storedFlags[3:2] <= flagsE[3:2];
      end
      if (flagWriteE[0]) begin
        storedFlags[1:0] <= flagsE[1:0];
      end
    end
  end

  // A stalled instruction has not yet left Execute
  flagsHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    stallE |=> $stable(storedFlags))
    else $error("stored flags changed during an Execute stall");

endmodule

// ==== logic/memMask.sv ====
`timescale 1ns/100ps

module memMask import armCtrlPkg::*; (
  input  memSizeT    sizeE,
  input  logic [1:0] offsetE,     // Address bits 1:0
  output logic [3:0] byteMaskE
);

  always_comb begin
    case (sizeE)
      SIZE_WORD: byteMaskE = 4'b1111;
      SIZE_HALF: byteMaskE = offsetE[1] ? 4'b1100 : 4'b0011;
      SIZE_BYTE: byteMaskE = 4'b0001 << offsetE;
      default:   byteMaskE = 4'b1111;
    endcase
  end

  always_comb begin
    maskNotEmpty: assert (byteMaskE != 4'b0000)
      else $error("empty byte mask for size %0d", sizeE);
  end

endmodule

// ==== logic/ctrlPipe.sv ====
`timescale 1ns/100ps

module ctrlPipe import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       stallE,
  input  logic       flushE,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       flushW,
  input  logic       aluSrcD,
  input  logic       memtoRegD,
  input  logic       regWriteD,
  input  logic       memWriteD,
  input  logic       branchD,
  input  logic       aluOpD,
  input  logic       multD,
  input  logic       pcSrcD,
  input  aluCtrlT    aluControlD,
  input  logic [1:0] flagWriteD,
  input  memSizeT    sizeD,
  input  logic [3:0] condD,
  input  logic       condExE,
  input  logic       noWriteE,
  input  logic [3:0] byteMaskE,
  input  logic [1:0] aluResultE,   // Low address bits only
  output logic       aluSrcE,
  output logic       aluOpE,
  output logic       memtoRegE,
  output logic       branchTakenE,
  output aluCtrlT    aluControlE,
  output logic [1:0] flagWriteE,
  output logic [3:0] condE,
  output memSizeT    sizeE,
  output logic       memWriteM,
  output logic       regWriteM,
  output logic       memtoRegM,
  output logic [3:0] byteMaskM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW,
  output memSizeT    sizeW,
  output logic [1:0] byteOffsetW,
  output logic       pcWrPendingF
);

  logic       regWriteE;
  logic       memWriteE;
  logic       branchE;
  logic       pcSrcE;
  logic       multE;
  logic [1:0] flagWriteRegE;
  logic       regWriteGatedE;
  logic       memWriteGatedE;
  logic       pcSrcGatedE;
  logic       pcSrcM;
  memSizeT    sizeM;
  logic [1:0] byteOffsetM;

  // ==============================
  // Execute
  // ==============================
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin     // Flush wins over stall
      aluSrcE       <= 1'b0;
      aluOpE        <= 1'b0;
      memtoRegE     <= 1'b0;
      regWriteE     <= 1'b0;
      memWriteE     <= 1'b0;
      branchE       <= 1'b0;
      pcSrcE        <= 1'b0;
      multE         <= 1'b0;
      aluControlE   <= ALU_AND;
      flagWriteRegE <= 2'b00;
      condE         <= 4'h0;
      sizeE         <= SIZE_WORD;
    end else if (!stallE) begin
      aluSrcE       <= aluSrcD;
      aluOpE        <= aluOpD;
      memtoRegE     <= memtoRegD;
      regWriteE     <= regWriteD;
      memWriteE     <= memWriteD;
      branchE       <= branchD;
      pcSrcE        <= pcSrcD;
      multE         <= multD;
      aluControlE   <= aluControlD;
      flagWriteRegE <= flagWriteD;
      condE         <= condD;
      sizeE         <= sizeD;
    end
  end

  // Multiplies leave C and V alone
  assign flagWriteE = {flagWriteRegE[1], flagWriteRegE[0] && !multE};

  // Writes and branches only when the condition passes
  assign regWriteGatedE = regWriteE && condExE && !noWriteE;
  assign memWriteGatedE = memWriteE && condExE;
  assign pcSrcGatedE    = pcSrcE && condExE;
  assign branchTakenE   = branchE && condExE;

  // ==============================
  // Memory
  // ==============================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM   <= 1'b0;
      regWriteM   <= 1'b0;
      memtoRegM   <= 1'b0;
      pcSrcM      <= 1'b0;
      byteMaskM   <= 4'b0000;
      sizeM       <= SIZE_WORD;
      byteOffsetM <= 2'b00;
    end else if (!stallM) begin
      memWriteM   <= memWriteGatedE;
      regWriteM   <= regWriteGatedE;
      memtoRegM   <= memtoRegE;
      pcSrcM      <= pcSrcGatedE;
      byteMaskM   <= byteMaskE;
      sizeM       <= sizeE;
      byteOffsetM <= aluResultE;
    end
  end

  // ==============================
  // Writeback
  // ==============================
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      regWriteW   <= 1'b0;
      memtoRegW   <= 1'b0;
      pcSrcW      <= 1'b0;
      sizeW       <= SIZE_WORD;
      byteOffsetW <= 2'b00;
    end else if (!stallW) begin
      regWriteW   <= regWriteM;
      memtoRegW   <= memtoRegM;
      pcSrcW      <= pcSrcM;
      sizeW       <= sizeM;
      byteOffsetW <= byteOffsetM;
    end
  end

  assign pcWrPendingF = pcSrcD || pcSrcE || pcSrcM;   // For fetch stall

  flushClearsE: assert property (@(posedge clk) disable iff (!rstN)
    (flushE && !stallE) |=> (!regWriteE && !memWriteE))
    else $error("write controls left in Execute after a flush");

endmodule

// ==== logic/controller.sv ====
`timescale 1ns/100ps

module controller import armCtrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  instrU       instrD,
  input  logic [3:0]  flagsE,
  input  logic [31:0] aluResultE,
  input  logic        stallE,
  input  logic        flushE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  output logic        aluSrcE,
  output aluCtrlT     aluControlE,
  output logic        aluCarryE,
  output logic        invertBE,
  output logic        branchTakenE,
  output logic        memtoRegE,
  output logic        memWriteM,
  output logic        regWriteM,
  output logic [3:0]  byteMaskM,
  output logic        regWriteW,
  output logic        memtoRegW,
  output logic        pcSrcW,
  output memSizeT     sizeW,
  output logic [1:0]  byteOffsetW,
  output logic        pcWrPendingF
);

  // Decode fields
  logic       aluSrcD;
  logic       memtoRegD;
  logic       regWriteD;
  logic       memWriteD;
  logic       branchD;
  logic       aluOpD;
  logic       multD;
  logic       pcSrcD;
  aluCtrlT    aluControlD;
  logic [1:0] flagWriteD;
  memSizeT    sizeD;

  // Execute feedback
  logic       aluOpE;
  logic [1:0] flagWriteE;
  logic [3:0] condE;
  memSizeT    sizeE;
  logic       condExE;
  logic       noWriteE;
  logic [3:0] byteMaskE;
  logic [3:0] storedFlags;

  mainDecoder mainDecoder_i (
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcD     (aluSrcD),
    .memtoRegD   (memtoRegD),
    .regWriteD   (regWriteD),
    .memWriteD   (memWriteD),
    .branchD     (branchD),
    .aluOpD      (aluOpD),
    .multD       (multD),
    .pcSrcD      (pcSrcD),
    .aluControlD (aluControlD),
    .flagWriteD  (flagWriteD),
    .sizeD       (sizeD)
  );

  ctrlPipe ctrlPipe_i (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .aluSrcD      (aluSrcD),
    .memtoRegD    (memtoRegD),
    .regWriteD    (regWriteD),
    .memWriteD    (memWriteD),
    .branchD      (branchD),
    .aluOpD       (aluOpD),
    .multD        (multD),
    .pcSrcD       (pcSrcD),
    .aluControlD  (aluControlD),
    .flagWriteD   (flagWriteD),
    .sizeD        (sizeD),
    .condD        (instrD.dpView.cond),
    .condExE      (condExE),
    .noWriteE     (noWriteE),
    .byteMaskE    (byteMaskE),
    .aluResultE   (aluResultE[1:0]),
    .aluSrcE      (aluSrcE),
    .aluOpE       (aluOpE),
    .memtoRegE    (memtoRegE),
    .branchTakenE (branchTakenE),
    .aluControlE  (aluControlE),
    .flagWriteE   (flagWriteE),
    .condE        (condE),
    .sizeE        (sizeE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .memtoRegM    (),               // Consumed inside the pipe only
    .byteMaskM    (byteMaskM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .sizeW        (sizeW),
    .byteOffsetW  (byteOffsetW),
    .pcWrPendingF (pcWrPendingF)
  );

  aluDecoder aluDecoder_i (
    .aluOpE      (aluOpE),
    .aluControlE (aluControlE),
    .carryFlagE  (storedFlags[1]),
    .noWriteE    (noWriteE),
    .aluCarryE   (aluCarryE),
    .invertBE    (invertBE)
  );

  condUnit condUnit_i (
    .clk         (clk),
    .rstN        (rstN),
    .stallE      (stallE),
    .condE       (condE),
    .flagsE      (flagsE),
    .flagWriteE  (flagWriteE),
    .condExE     (condExE),
    .storedFlags (storedFlags)
  );

  memMask memMask_i (
    .sizeE     (sizeE),
    .offsetE   (aluResultE[1:0]),
    .byteMaskE (byteMaskE)
  );

endmodule

// ==== dv/tbController.sv ====
`timescale 1ns/100ps

module tbController import armCtrlPkg::*; ();

  localparam int CLK_PERIOD    = 8;
  localparam int CYCLES_PER_ROW = 4;   // D, E, M and W checks
  localparam int NUM_ROWS      = 24;

  // Decoded expectation per instruction before condition gating
  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  flags;      // NZCV the ALU returns in Execute
    logic [31:0] addr;       // Low two bits replaced by random offset
    logic        stall;
    logic        flush;
    logic [1:0]  regSrc;
    logic [1:0]  immSrc;
    aluCtrlT     aluCtrl;
    logic        aluSrc;
    logic        branch;
    logic        regWr;
    logic        memWr;
    logic        memtoReg;
    logic        pcSrc;
    memSizeT     size;
    logic        setsFlags;
  } rowT;

  logic        clk;
  logic        rstN;
  instrU       instrD;
  logic [3:0]  flagsE;
  logic [31:0] aluResultE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  aluCtrlT     aluControlE;
  logic        aluCarryE;
  logic        invertBE;
  logic        branchTakenE;
  logic        memtoRegE;
  logic        memWriteM;
  logic        regWriteM;
  logic [3:0]  byteMaskM;
  logic        regWriteW;
  logic        memtoRegW;
  logic        pcSrcW;
  memSizeT     sizeW;
  logic [1:0]  byteOffsetW;
  logic        pcWrPendingF;

  rowT         rows [NUM_ROWS];
  int          rowCount;
  int          errCount;
  int          checkCount;
  integer      seed;
  logic [3:0]  modelFlags;   // NZCV as the testbench expects them stored

  controller dut_i (
    .clk(clk), .rstN(rstN), .instrD(instrD), .flagsE(flagsE), .aluResultE(aluResultE),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .aluCarryE(aluCarryE), .invertBE(invertBE), .branchTakenE(branchTakenE),
    .memtoRegE(memtoRegE), .memWriteM(memWriteM), .regWriteM(regWriteM),
    .byteMaskM(byteMaskM), .regWriteW(regWriteW), .memtoRegW(memtoRegW),
    .pcSrcW(pcSrcW), .sizeW(sizeW), .byteOffsetW(byteOffsetW), .pcWrPendingF(pcWrPendingF)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // Reference rules
  // ==============================
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n, z, c, v;
    {n, z, c, v} = nzcv;
    case (cond)
      COND_EQ: return z;
      COND_NE: return !z;
      COND_CS: return c;
      COND_CC: return !c;
      COND_MI: return n;
      COND_PL: return !n;
      COND_VS: return v;
      COND_VC: return !v;
      COND_HI: return c && !z;
      COND_LS: return !c || z;
      COND_GE: return n == v;
      COND_LT: return n != v;
      COND_GT: return !z && (n == v);
      COND_LE: return z || (n != v);
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic carryIn(input aluCtrlT op, input logic cFlag);
    case (op)
      ALU_ADC, ALU_SBC: return cFlag;
      ALU_SUB, ALU_CMP: return 1'b1;
      default:          return 1'b0;
    endcase
  endfunction

  // Subtract forms add the inverted B operand
  function automatic logic invertsB(input aluCtrlT op);
    case (op)
      ALU_SUB, ALU_SBC, ALU_CMP: return 1'b1;
      default:                   return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] laneMask(input memSizeT size, input logic [1:0] offset);
    case (size)
      SIZE_HALF: return offset[1] ? 4'b1100 : 4'b0011;
      SIZE_BYTE: return 4'b0001 << offset;   // One lane at the offset
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic rowT makeRow(
    input logic [31:0] instr, input logic [3:0] flags, input logic [31:0] addr,
    input logic stall, input logic flush, input logic [1:0] regSrc, input logic [1:0] immSrc,
    input aluCtrlT aluCtrl, input logic aluSrc, input logic branch, input logic regWr,
    input logic memWr, input logic memtoReg, input logic pcSrc, input memSizeT size,
    input logic setsFlags);
    rowT r;
    r = {instr, flags, addr, stall, flush, regSrc, immSrc, aluCtrl, aluSrc, branch,
         regWr, memWr, memtoReg, pcSrc, size, setsFlags};
    return r;
  endfunction

  task automatic addRow(input rowT r);
    rows[rowCount] = r;
    rowCount++;
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic checkBit(input string what, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkSel(input string what, input logic [1:0] got, input logic [1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkAluCtrl(input string what, input aluCtrlT got, input aluCtrlT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkSize(input string what, input memSizeT got, input memSizeT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkMask(input string what, input logic [3:0] got, input logic [3:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Each row holds instr, flagsE, address, stallE and flushE, then the expected regSrc,
  // immSrc, aluCtrl, aluSrc, branch, regWrite, memWrite, memtoReg, pcSrc, size, setsFlags
  task automatic loadTable();
    addRow(makeRow(32'hE282_1005, 4'b0000, 32'h0000_1000, 0, 0,   // ADD r1, r2, #5
                   2'b00, IMM_DP, ALU_ADD, 1, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE151_0002, 4'b0110, 32'h0000_1000, 0, 0,   // CMP r1, r2 gives Z C
                   2'b00, IMM_DP, ALU_CMP, 0, 0, 0, 0, 0, 0, SIZE_WORD, 1));
    addRow(makeRow(32'h0A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BEQ
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h1A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BNE
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h8A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BHI
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h9A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BLS
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h1283_3001, 4'b0000, 32'h0000_1000, 0, 0,   // ADDNE fails on Z
                   2'b00, IMM_DP, ALU_ADD, 1, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE0A4_4005, 4'b0000, 32'h0000_1000, 0, 0,   // ADC r4, r4, r5
                   2'b00, IMM_DP, ALU_ADC, 0, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE582_1008, 4'b0000, 32'h0000_2000, 0, 0,   // STR r1, [r2, #8]
                   REG_SRC_RD, IMM_MEM, ALU_ADD, 1, 0, 0, 1, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE542_1003, 4'b0000, 32'h0000_2004, 0, 0,   // STRB r1, [r2, #-3]
                   REG_SRC_RD, IMM_MEM, ALU_SUB, 1, 0, 0, 1, 0, 0, SIZE_BYTE, 0));
    addRow(makeRow(32'hE1C2_10B2, 4'b0000, 32'h0000_2008, 0, 0,   // STRH r1, [r2, #2]
                   REG_SRC_RD, IMM_HALF, ALU_ADD, 1, 0, 0, 1, 0, 0, SIZE_HALF, 0));
    addRow(makeRow(32'hE1D2_60B2, 4'b0000, 32'h0000_200C, 0, 0,   // LDRH r6, [r2, #2]
                   2'b00, IMM_HALF, ALU_ADD, 1, 0, 1, 0, 1, 0, SIZE_HALF, 0));
    addRow(makeRow(32'hE512_7004, 4'b0000, 32'h0000_2010, 0, 1,   // LDR flushed out of E
                   2'b00, IMM_MEM, ALU_SUB, 1, 0, 1, 0, 1, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE3A0_8000, 4'b0000, 32'h0000_0000, 0, 0,   // MOV r8, #0
                   2'b00, IMM_DP, ALU_MOV, 1, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE249_9001, 4'b0000, 32'h0000_1000, 1, 0,   // SUB while E stalls
                   2'b00, IMM_DP, ALU_SUB, 1, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE1A0_F00E, 4'b0000, 32'h0000_3000, 0, 0,   // MOV pc, lr
                   2'b00, IMM_DP, ALU_MOV, 0, 0, 1, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'hE12F_FF1E, 4'b0000, 32'h0000_3000, 0, 0,   // BX lr
                   2'b00, IMM_DP, ALU_MOV, 0, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'hE001_0392, 4'b0000, 32'h0000_0000, 0, 0,   // MUL r1, r2, r3
                   2'b00, IMM_DP, ALU_ADD, 0, 0, 1, 0, 0, 0, SIZE_WORD, 0));
    addRow(makeRow(32'hE151_0002, 4'b1000, 32'h0000_1000, 0, 0,   // CMP gives N only
                   2'b00, IMM_DP, ALU_CMP, 0, 0, 0, 0, 0, 0, SIZE_WORD, 1));
    addRow(makeRow(32'hBA00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BLT
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'hAA00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BGE
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h4A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BMI
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'h6A00_0004, 4'b0000, 32'h0000_2000, 0, 0,   // BVS
                   REG_SRC_PC, IMM_BR, ALU_ADD, 1, 1, 0, 0, 0, 1, SIZE_WORD, 0));
    addRow(makeRow(32'hE5D2_7001, 4'b0000, 32'h0000_2014, 0, 0,   // LDRB r7, [r2, #1]
                   2'b00, IMM_MEM, ALU_ADD, 1, 0, 1, 0, 1, 0, SIZE_BYTE, 0));
  endtask

  // ==============================
  // Stimulus and checks
  // ==============================
  initial begin
    rowT         cur;
    rowT         prev;
    rowT         eff;
    rowT         zeroRow;
    logic [31:0] addrE;
    integer      rnd;
    logic        passE;
    clk        = 1'b0;
    rstN       = 1'b0;
    instrD     = 32'hE1A0_0000;   // MOV r0, r0
    flagsE     = 4'b0000;
    aluResultE = 32'h0;
    stallE     = 1'b0;
    flushE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    seed       = 32'h376a_9271;
    errCount   = 0;
    checkCount = 0;
    rowCount   = 0;
    modelFlags = 4'b0000;
    loadTable();
    zeroRow = makeRow(32'h0, 4'h0, 32'h0, 0, 0, 2'b00, 2'b00, ALU_AND, 0, 0, 0, 0, 0, 0,
                      SIZE_WORD, 0);
    prev = makeRow(32'hE1A0_0000, 4'h0, 32'h0, 0, 0, 2'b00, IMM_DP, ALU_MOV, 0, 0, 1, 0, 0,
                   0, SIZE_WORD, 0);
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkBit("reset memWriteM", memWriteM, 1'b0);
    checkBit("reset regWriteM", regWriteM, 1'b0);
    checkBit("reset regWriteW", regWriteW, 1'b0);
    checkBit("reset pcSrcW", pcSrcW, 1'b0);
    checkBit("reset branchTakenE", branchTakenE, 1'b0);
    checkBit("reset pcWrPendingF", pcWrPendingF, 1'b0);

    for (int i = 0; i < rowCount; i++) begin
      cur   = rows[i];
      rnd   = $random(seed);
      addrE = {cur.addr[31:2], rnd[1:0]};
      // What Execute holds the cycle after this row enters Decode
      eff = cur.flush ? zeroRow : (cur.stall ? prev : cur);

      @(posedge clk);   // Decode
      instrD <= cur.instr;
      stallE <= cur.stall;
      flushE <= cur.flush;
      @(negedge clk);
      checkSel($sformatf("row %0d regSrcD", i), regSrcD, cur.regSrc);
      checkSel($sformatf("row %0d immSrcD", i), immSrcD, cur.immSrc);
      checkBit($sformatf("row %0d pcWrPendingF", i), pcWrPendingF, cur.pcSrc | prev.pcSrc);

      @(posedge clk);   // Execute
      stallE     <= 1'b0;
      flushE     <= 1'b0;
      flagsE     <= cur.flags;
      aluResultE <= addrE;
      @(negedge clk);
      passE = condHolds(eff.instr[31:28], modelFlags);
      checkAluCtrl($sformatf("row %0d aluControlE", i), aluControlE, eff.aluCtrl);
      checkBit($sformatf("row %0d aluSrcE", i), aluSrcE, eff.aluSrc);
      checkBit($sformatf("row %0d aluCarryE", i), aluCarryE,
               carryIn(eff.aluCtrl, modelFlags[1]));
      checkBit($sformatf("row %0d invertBE", i), invertBE, invertsB(eff.aluCtrl));
      checkBit($sformatf("row %0d branchTakenE", i), branchTakenE, eff.branch && passE);
      checkBit($sformatf("row %0d memtoRegE", i), memtoRegE, eff.memtoReg);

      @(posedge clk);   // Memory
      @(negedge clk);
      checkBit($sformatf("row %0d memWriteM", i), memWriteM, eff.memWr && passE);
      checkBit($sformatf("row %0d regWriteM", i), regWriteM, eff.regWr && passE);
      checkMask($sformatf("row %0d byteMaskM", i), byteMaskM, laneMask(eff.size, addrE[1:0]));

      @(posedge clk);   // Writeback
      @(negedge clk);
      checkBit($sformatf("row %0d regWriteW", i), regWriteW, eff.regWr && passE);
      checkBit($sformatf("row %0d memtoRegW", i), memtoRegW, eff.memtoReg);
      checkBit($sformatf("row %0d pcSrcW", i), pcSrcW, eff.pcSrc && passE);
      checkSize($sformatf("row %0d sizeW", i), sizeW, eff.size);
      checkSel($sformatf("row %0d byteOffsetW", i), byteOffsetW, addrE[1:0]);

      if (cur.setsFlags && condHolds(cur.instr[31:28], modelFlags)) begin
        modelFlags = cur.flags;
      end
      prev = cur;
    end

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Twice the expected run length with reset included
  initial begin
    #((NUM_ROWS * CYCLES_PER_ROW + 10) * CLK_PERIOD * 2);
    $display("Timeout: the watchdog expired before the table was finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== tb.f ====
logic/armCtrlPkg.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/condUnit.sv
logic/memMask.sv
logic/ctrlPipe.sv
logic/controller.sv
dv/tbController.sv
